//--- Makefile
VERILATOR    ?= verilator
TB_TOP       := mem_subsys_tb
RTL_TOP      := mem_subsys_top
FILELIST     := mem_subsys_top.f
OBJ_DIR      := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --assert --timescale 1ns/1ps -f $(FILELIST)
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
SIM_FLAGS    := --binary -j 0 $(COMMON_FLAGS) -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/dmem_if.sv
`default_nettype none

interface dmem_if;
    import mem_pkg::*;

    // Write request, address and data in one beat
    logic awvalid;
    word_t awaddr;
    word_t wdata;
    strb_t wstrb;

    // Write response
    logic bvalid;
    logic bready;

    // Read request and response
    logic arvalid;
    word_t araddr;
    logic rvalid;
    word_t rdata;

    // SRAM is always ready, so no awready or arready
    modport master (
        output awvalid, awaddr, wdata, wstrb,
        input  bvalid,
        output bready,
        output arvalid, araddr,
        input  rvalid, rdata
    );

    modport slave (
        input  awvalid, awaddr, wdata, wstrb,
        output bvalid,
        input  bready,
        input  arvalid, araddr,
        output rvalid, rdata
    );

endinterface

`default_nettype wire

//--- common/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Datapath widths
`define MEM_DATA_WIDTH 32
`define MEM_REG_ADDR_WIDTH 5

// Data SRAM geometry, in words; upper address bits wrap
`define MEM_DMEM_WORDS 256

// Cycles from request acceptance to response valid
`define MEM_DMEM_LATENCY 2

// RV32I major opcodes handled by the memory stage
`define MEM_OPCODE_LOAD 7'b0000011
`define MEM_OPCODE_STORE 7'b0100011

// funct3 encodings for reference
//   000 LB/SB   001 LH/SH   010 LW/SW
//   100 LBU     101 LHU
// Bit 2 selects zero extension on loads

`endif

//--- common/mem_pkg.sv
`include "mem_cfg.svh"

`default_nettype none

package mem_pkg;

    // One data word and one register index
    typedef logic [`MEM_DATA_WIDTH-1:0] word_t;
    typedef logic [`MEM_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // One strobe bit per byte lane
    typedef logic [`MEM_DATA_WIDTH/8-1:0] strb_t;

    // Access size, from funct3[1:0]
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } access_width_e;

    // Size code 11 has no RV32 meaning, treated as a word
    function automatic access_width_e width_of_funct3(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00: return ACC_BYTE;
            2'b01: return ACC_HALF;
            default: return ACC_WORD;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- mem_subsys_top.f
+incdir+common
common/mem_pkg.sv
common/dmem_if.sv
src/mem_stage/store_formatter.sv
src/mem_stage/load_aligner.sv
src/mem_stage/mem_stage.sv
src/dmem_sram.sv
src/mem_subsys_top.sv
test/mem_subsys_tb.sv

//--- src/dmem_sram.sv
`include "mem_cfg.svh"

`default_nettype none

module dmem_sram (
    input  wire logic clk,
    input  wire logic rst,
    dmem_if.slave     dmem
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_DMEM_WORDS);
    localparam int LAT = `MEM_DMEM_LATENCY;
    localparam int LANES = `MEM_DATA_WIDTH / 8;

    word_t mem_q [`MEM_DMEM_WORDS];
    word_t rdata_pipe [LAT];
    logic [LAT-1:0] r_pipe;
    logic [LAT-1:0] b_pipe;
    logic b_hold;
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;

    // Word index sits above the byte offset, higher bits wrap
    assign widx = dmem.awaddr[IDX_W+1:2];
    assign ridx = dmem.araddr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (dmem.awvalid) begin
            for (int i = 0; i < LANES; i++) begin
                if (dmem.wstrb[i]) begin
                    mem_q[widx][i*8 +: 8] <= dmem.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read word enters the pipe at acceptance
    always_ff @(posedge clk) begin
        rdata_pipe[0] <= mem_q[ridx];
        for (int i = 1; i < LAT; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_pipe <= '0;
            b_pipe <= '0;
            b_hold <= 1'b0;
        end else begin
            r_pipe <= (r_pipe << 1) | LAT'(dmem.arvalid);
            b_pipe <= (b_pipe << 1) | LAT'(dmem.awvalid);
            // keep the write response up until the master takes it
            b_hold <= dmem.bvalid && !dmem.bready;
        end
    end

    assign dmem.rvalid = r_pipe[LAT-1];
    assign dmem.rdata = rdata_pipe[LAT-1];
    assign dmem.bvalid = b_pipe[LAT-1] | b_hold;

    // Single port array, one access per cycle
    a_no_rw_collision: assert property (@(posedge clk) disable iff (rst)
        !(dmem.arvalid && dmem.awvalid))
        else $error("read and write request in the same cycle");

endmodule

`default_nettype wire

//--- src/mem_stage/load_aligner.sv
`include "mem_cfg.svh"

`default_nettype none

module load_aligner (
    input  mem_pkg::access_width_e width_i,
    input  wire logic              unsigned_i,
    input  wire logic [1:0]        addr_lo_i,
    input  mem_pkg::word_t         rdata_i,
    output mem_pkg::word_t         data_o
);
    import mem_pkg::*;

    logic [7:0] ld_byte;
    logic [15:0] ld_half;
    logic byte_fill;
    logic half_fill;

    // Lane select by byte offset
    assign ld_byte = rdata_i[{addr_lo_i, 3'b000} +: 8];
    assign ld_half = rdata_i[{addr_lo_i[1], 4'b0000} +: 16];

    // Fill bit is the sign for LB/LH, zero for LBU/LHU
    assign byte_fill = ld_byte[7] & ~unsigned_i;
    assign half_fill = ld_half[15] & ~unsigned_i;

    always_comb begin
        case (width_i)
            ACC_BYTE: begin
                data_o = {{(`MEM_DATA_WIDTH-8){byte_fill}}, ld_byte};
            end
            ACC_HALF: begin
                data_o = {{(`MEM_DATA_WIDTH-16){half_fill}}, ld_half};
            end
            default: begin
                data_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/mem_stage/mem_stage.sv
`include "mem_cfg.svh"

`default_nettype none

module mem_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    // Bundle from execute
    input  wire logic              exu_valid_i,
    input  mem_pkg::word_t         pc_i,
    input  mem_pkg::word_t         inst_i,
    input  mem_pkg::word_t         result_i,
    input  mem_pkg::word_t         addr_i,
    input  mem_pkg::word_t         rs2_data_i,
    input  mem_pkg::reg_addr_t     rd_addr_i,
    // Bundle to writeback
    output mem_pkg::word_t         pc_o,
    output mem_pkg::word_t         inst_o,
    output mem_pkg::word_t         result_o,
    output mem_pkg::word_t         rdata_o,
    output mem_pkg::reg_addr_t     rd_addr_o,
    output logic                   done_o,
    output logic                   busy_o,
    // Data memory
    dmem_if.master                 dmem
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WAIT,
        ST_DONE
    } state_e;

    state_e state;

    word_t pc_q;
    word_t inst_q;
    word_t result_q;
    word_t addr_q;
    word_t rs2_q;
    reg_addr_t rd_q;
    word_t rdata_q;

    logic capture;
    logic in_is_mem;
    logic is_load;
    logic is_store;
    access_width_e width;
    logic [1:0] st_addr_lo;
    word_t load_data;
    logic arvalid_q;
    logic awvalid_q;
    logic req_pending;

    // Only the incoming opcode decides whether memory is touched
    assign capture = (state == ST_IDLE) && exu_valid_i;
    assign in_is_mem = (inst_i[6:0] == `MEM_OPCODE_LOAD) ||
                       (inst_i[6:0] == `MEM_OPCODE_STORE);

    // Decode from the captured instruction
    assign is_load = (inst_q[6:0] == `MEM_OPCODE_LOAD);
    assign is_store = (inst_q[6:0] == `MEM_OPCODE_STORE);
    assign width = width_of_funct3(inst_q[14:12]);

    // Lane offset only matters for stores
    assign st_addr_lo = is_store ? addr_q[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (capture) begin
            pc_q <= pc_i;
            inst_q <= inst_i;
            result_q <= result_i;
            addr_q <= addr_i;
            rs2_q <= rs2_data_i;
            rd_q <= rd_addr_i;
        end
    end

    // Read data stays zero unless a load returns
    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= '0;
        end else if (state == ST_WAIT && dmem.rvalid && is_load) begin
            rdata_q <= load_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
        end else begin
            // Request valids last a single cycle
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (exu_valid_i) begin
                        state <= in_is_mem ? ST_ACCESS : ST_DONE;
                    end
                end
                ST_ACCESS: begin
                    arvalid_q <= is_load;
                    awvalid_q <= is_store;
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (dmem.rvalid || dmem.bvalid) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    store_formatter u_store_formatter (
        .width_i    (width),
        .addr_lo_i  (st_addr_lo),
        .rs2_data_i (rs2_q),
        .wstrb_o    (dmem.wstrb),
        .wdata_o    (dmem.wdata)
    );

    load_aligner u_load_aligner (
        .width_i    (width),
        .unsigned_i (inst_q[14]),
        .addr_lo_i  (addr_q[1:0]),
        .rdata_i    (dmem.rdata),
        .data_o     (load_data)
    );

    assign dmem.arvalid = arvalid_q;
    assign dmem.awvalid = awvalid_q;
    assign dmem.araddr = addr_q;
    assign dmem.awaddr = addr_q;
    assign dmem.bready = 1'b1;

    assign pc_o = pc_q;
    assign inst_o = inst_q;
    assign result_o = result_q;
    assign rdata_o = rdata_q;
    assign rd_addr_o = rd_q;
    assign done_o = (state == ST_DONE);
    assign busy_o = (state != ST_IDLE);

    // Tracks an issued request until its response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_pending <= 1'b0;
        end else if (dmem.arvalid || dmem.awvalid) begin
            req_pending <= 1'b1;
        end else if (dmem.rvalid || dmem.bvalid) begin
            req_pending <= 1'b0;
        end
    end

    // SRAM responses must land while the FSM is waiting for them
    a_resp_in_wait: assert property (@(posedge clk) disable iff (rst)
        (dmem.rvalid || dmem.bvalid) |-> (state == ST_WAIT))
        else $error("dmem response outside wait state");

    a_single_outstanding: assert property (@(posedge clk) disable iff (rst)
        (dmem.arvalid || dmem.awvalid) |-> !req_pending)
        else $error("dmem request issued while another is outstanding");

endmodule

`default_nettype wire

//--- src/mem_stage/store_formatter.sv
`include "mem_cfg.svh"

`default_nettype none

module store_formatter (
    input  mem_pkg::access_width_e width_i,
    input  wire logic [1:0]        addr_lo_i,
    input  mem_pkg::word_t         rs2_data_i,
    output mem_pkg::strb_t         wstrb_o,
    output mem_pkg::word_t         wdata_o
);
    import mem_pkg::*;

    logic [7:0] st_byte;
    logic [15:0] st_half;

    assign st_byte = rs2_data_i[7:0];
    assign st_half = rs2_data_i[15:0];

    // Data is copied to every lane, strobes pick the live ones
    always_comb begin
        case (width_i)
            ACC_BYTE: begin
                wdata_o = {(`MEM_DATA_WIDTH/8){st_byte}};
                wstrb_o = strb_t'(1) << addr_lo_i;
            end
            ACC_HALF: begin
                wdata_o = {(`MEM_DATA_WIDTH/16){st_half}};
                wstrb_o = strb_t'(2'b11) << {addr_lo_i[1], 1'b0};
            end
            default: begin
                wdata_o = rs2_data_i;
                wstrb_o = '1;
            end
        endcase
    end

    // Misaligned stores have no trap path, so they must never reach here
    always_comb begin
        if (!$isunknown({width_i, addr_lo_i})) begin
            a_store_aligned: assert final (
                (width_i != ACC_HALF || !addr_lo_i[0]) &&
                (width_i != ACC_WORD || addr_lo_i == 2'b00))
                else $error("misaligned store, width %0d offset %0d",
                            width_i, addr_lo_i);
        end
    end

endmodule

`default_nettype wire

//--- src/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top (
    input  wire logic          clk,
    input  wire logic          rst,
    // From execute
    input  wire logic          exu_valid_i,
    input  mem_pkg::word_t     pc_i,
    input  mem_pkg::word_t     inst_i,
    input  mem_pkg::word_t     result_i,
    input  mem_pkg::word_t     addr_i,
    input  mem_pkg::word_t     rs2_data_i,
    input  mem_pkg::reg_addr_t rd_addr_i,
    // To writeback
    output mem_pkg::word_t     pc_o,
    output mem_pkg::word_t     inst_o,
    output mem_pkg::word_t     result_o,
    output mem_pkg::word_t     rdata_o,
    output mem_pkg::reg_addr_t rd_addr_o,
    output logic               done_o,
    output logic               busy_o
);

    // Request and response channel to the data SRAM
    dmem_if dmem_bus ();

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .exu_valid_i (exu_valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .addr_i      (addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .result_o    (result_o),
        .rdata_o     (rdata_o),
        .rd_addr_o   (rd_addr_o),
        .done_o      (done_o),
        .busy_o      (busy_o),
        .dmem        (dmem_bus.master)
    );

    dmem_sram u_dmem_sram (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem_bus.slave)
    );

endmodule

`default_nettype wire

//--- test/mem_subsys_tb.sv
`include "mem_cfg.svh"

`default_nettype none

module mem_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int WAIT_LIMIT = 40;
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    // One instruction with its expected load result
    typedef struct packed {
        word_t     inst;
        word_t     addr;
        word_t     rs2;
        reg_addr_t rd;
        word_t     pc;
        word_t     result;
        word_t     exp_rdata;
        logic      stray;
    } row_t;

    logic      clk;
    logic      rst;
    logic      exu_valid_i;
    word_t     pc_i;
    word_t     inst_i;
    word_t     result_i;
    word_t     addr_i;
    word_t     rs2_data_i;
    reg_addr_t rd_addr_i;
    word_t     pc_o;
    word_t     inst_o;
    word_t     result_o;
    word_t     rdata_o;
    reg_addr_t rd_addr_o;
    logic      done_o;
    logic      busy_o;

    row_t rows[$];
    int   errors = 0;
    int   checks = 0;
    int   timeouts = 0;
    logic abort_run = 1'b0;

    mem_subsys_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .exu_valid_i (exu_valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .addr_i      (addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .result_o    (result_o),
        .rdata_o     (rdata_o),
        .rd_addr_o   (rd_addr_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    // Random pc, result and rd are fixed here, before the row runs
    task automatic build_row(input logic [6:0] opcode, input logic [2:0] funct3,
                             input word_t addr, input word_t rs2,
                             input word_t exp_rdata, input logic stray);
        row_t row;
        row.rd = reg_addr_t'($urandom);
        row.pc = $urandom;
        row.result = $urandom;
        row.inst = {17'h0, funct3, row.rd, opcode};
        row.addr = addr;
        row.rs2 = rs2;
        row.exp_rdata = exp_rdata;
        row.stray = stray;
        rows.push_back(row);
    endtask

    // Stores never return read data
    task automatic store_op(input logic [2:0] funct3, input word_t addr,
                            input word_t data, input logic stray);
        build_row(`MEM_OPCODE_STORE, funct3, addr, data, 32'h0, stray);
    endtask

    task automatic load_op(input logic [2:0] funct3, input word_t addr,
                           input word_t exp, input logic stray);
        build_row(`MEM_OPCODE_LOAD, funct3, addr, 32'h5a5a5a5a, exp, stray);
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        int waited;
        row = rows[idx];

        waited = 0;
        @(negedge clk);
        while (busy_o !== 1'b0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (busy_o !== 1'b0) begin
            $display("Timeout: stage still busy before row %0d", idx);
            timeouts++;
            errors++;
            abort_run = 1'b1;
            return;
        end

        @(posedge clk);
        exu_valid_i <= 1'b1;
        pc_i <= row.pc;
        inst_i <= row.inst;
        result_i <= row.result;
        addr_i <= row.addr;
        rs2_data_i <= row.rs2;
        rd_addr_i <= row.rd;

        // Capture edge; scrambled inputs must not reach the outputs
        @(posedge clk);
        exu_valid_i <= row.stray;
        pc_i <= ~row.pc;
        inst_i <= ~row.inst;
        result_i <= ~row.result;
        addr_i <= ~row.addr;
        rs2_data_i <= ~row.rs2;
        rd_addr_i <= ~row.rd;
        if (row.stray) begin
            @(posedge clk);
            exu_valid_i <= 1'b0;
        end

        waited = 0;
        @(negedge clk);
        while (done_o !== 1'b1 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (done_o !== 1'b1) begin
            $display("Timeout: no done pulse for row %0d", idx);
            timeouts++;
            errors++;
            abort_run = 1'b1;
            return;
        end

        check_value("busy_o at done", word_t'(busy_o), 32'h1);
        check_value("pc_o", pc_o, row.pc);
        check_value("inst_o", inst_o, row.inst);
        check_value("result_o", result_o, row.result);
        check_value("rd_addr_o", word_t'(rd_addr_o), word_t'(row.rd));
        check_value("rdata_o", rdata_o, row.exp_rdata);

        // Done is a single cycle pulse
        @(negedge clk);
        check_value("done_o after pulse", word_t'(done_o), 32'h0);
        if (row.stray) begin
            repeat (6) begin
                @(negedge clk);
                check_value("done_o after ignored strobe", word_t'(done_o), 32'h0);
                check_value("busy_o after ignored strobe", word_t'(busy_o), 32'h0);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h57b91d68));
        rst = 1'b1;
        exu_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        result_i = '0;
        addr_i = '0;
        rs2_data_i = '0;
        rd_addr_i = '0;

        // Word round trip, the first store also gets a stray strobe
        store_op(3'b010, 32'h0000_0010, 32'hdeadbeef, 1'b1);
        store_op(3'b010, 32'h0000_0024, 32'h12345678, 1'b0);
        load_op(3'b010, 32'h0000_0010, 32'hdeadbeef, 1'b1);
        load_op(3'b010, 32'h0000_0024, 32'h12345678, 1'b0);
        // Upper address bits wrap onto the same word
        load_op(3'b010, 32'h0000_0410, 32'hdeadbeef, 1'b0);

        // Byte lanes into a zeroed word
        store_op(3'b010, 32'h0000_0040, 32'h0, 1'b0);
        store_op(3'b000, 32'h0000_0040, 32'hffffffa1, 1'b0);
        store_op(3'b000, 32'h0000_0041, 32'h000000b2, 1'b0);
        store_op(3'b000, 32'h0000_0042, 32'h777777c3, 1'b0);
        store_op(3'b000, 32'h0000_0043, 32'h000000d4, 1'b0);
        load_op(3'b010, 32'h0000_0040, 32'hd4c3b2a1, 1'b0);

        // Both halves of another zeroed word
        store_op(3'b010, 32'h0000_0044, 32'h0, 1'b0);
        store_op(3'b001, 32'h0000_0044, 32'haaaa1357, 1'b0);
        store_op(3'b001, 32'h0000_0046, 32'h5555f00d, 1'b1);
        load_op(3'b010, 32'h0000_0044, 32'hf00d1357, 1'b0);

        // Sign and zero extension
        load_op(3'b000, 32'h0000_0042, 32'hffffffc3, 1'b1);
        load_op(3'b100, 32'h0000_0042, 32'h000000c3, 1'b0);
        load_op(3'b000, 32'h0000_0040, 32'hffffffa1, 1'b0);
        load_op(3'b100, 32'h0000_0043, 32'h000000d4, 1'b0);
        load_op(3'b001, 32'h0000_0046, 32'hfffff00d, 1'b0);
        load_op(3'b101, 32'h0000_0046, 32'h0000f00d, 1'b0);
        load_op(3'b001, 32'h0000_0044, 32'h00001357, 1'b0);

        // Other opcodes leave memory alone
        build_row(OP_REG, 3'b010, 32'h0000_0010, 32'h0bad0bad, 32'h0, 1'b0);
        build_row(OP_IMM, 3'b000, 32'h0000_0040, 32'hcafef00d, 32'h0, 1'b0);
        load_op(3'b010, 32'h0000_0010, 32'hdeadbeef, 1'b0);
        load_op(3'b010, 32'h0000_0040, 32'hd4c3b2a1, 1'b0);

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Quiet until the first strobe
        repeat (4) begin
            @(negedge clk);
            check_value("done_o after reset", word_t'(done_o), 32'h0);
            check_value("busy_o after reset", word_t'(busy_o), 32'h0);
        end

        for (int i = 0; i < rows.size() && !abort_run; i++) begin
            apply_row(i);
        end

        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
